// ==== rtl/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    ////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;      // Bus data and address word
    typedef logic [7:0]  byte_t;      // GPIO value, print character
    typedef logic [3:0]  wstrb_t;     // Write strobe, nonzero = store
    typedef logic [7:0]  gpio_tag_t;  // Meaning of the GPIO register

    // GPIO tag codes
    localparam gpio_tag_t TAG_OUTPUT = 8'h84;   // Data byte written
    localparam gpio_tag_t TAG_END    = 8'h80;   // End of program

    ////////////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////////////

    localparam word_t ADDR_END   = 32'h8000_0000;
    localparam word_t ADDR_PRINT = 32'h8000_1000;
    localparam word_t ADDR_GPIO  = 32'h8000_4000;
    localparam word_t ADDR_TIMER = 32'h8000_6000;   // Only readable address

    // Interrupt vector bit positions
    localparam int unsigned IRQ_TIMER_BIT = 7;
    localparam int unsigned IRQ_EXT_BIT   = 11;

    // Serial transmitter bit phases
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_t;

endpackage

`default_nettype wire

// ==== rtl/periph_bus_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_bus_decode (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  enable_i,
    input  wire periph_pkg::wstrb_t    write_enable_i,
    input  wire periph_pkg::word_t     data_address_i,
    input  wire periph_pkg::word_t     data_i,
    input  wire logic                  fifo_full_i,
    input  wire periph_pkg::word_t     timer_count_i,
    output periph_pkg::byte_t          gpio_out_o,
    output periph_pkg::gpio_tag_t      gpio_tag_o,
    output logic                       fifo_push_o,
    output periph_pkg::byte_t          fifo_data_o,
    output logic                       stall_o,
    output periph_pkg::word_t          data_o
);

    logic              is_store, is_load;
    logic              hit_end, hit_print, hit_gpio, hit_timer;
    logic              out_store;     // Store to GPIO or print
    logic              out_accept;    // ... and FIFO has room
    logic              stall_r;       // Stall of previous cycle
    periph_pkg::word_t data_r;        // First read stage

    // Access kind
    assign is_store = enable_i && (write_enable_i != '0);
    assign is_load  = enable_i && (write_enable_i == '0);

    // Address match
    assign hit_end   = (data_address_i == periph_pkg::ADDR_END);
    assign hit_print = (data_address_i == periph_pkg::ADDR_PRINT);
    assign hit_gpio  = (data_address_i == periph_pkg::ADDR_GPIO);
    assign hit_timer = (data_address_i == periph_pkg::ADDR_TIMER);

    assign out_store  = is_store && (hit_gpio || hit_print);
    assign out_accept = out_store && !fifo_full_i;

    //////////////////////////////////////////////////////////////////////
    // Stores
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio_out_o  <= '0;
            gpio_tag_o  <= '0;
            fifo_push_o <= 1'b0;
        end else if (out_accept) begin
            gpio_out_o  <= data_i[7:0];
            gpio_tag_o  <= periph_pkg::TAG_OUTPUT;
            fifo_push_o <= 1'b1;             // One push per accepted store
        end else if (is_store && hit_end) begin
            gpio_tag_o  <= periph_pkg::TAG_END; // GPIO value kept
            fifo_push_o <= 1'b0;
        end else begin
            gpio_out_o  <= '0;               // Back to zero when idle
            gpio_tag_o  <= '0;
            fifo_push_o <= 1'b0;
        end
    end

    // Byte travels with the push strobe
    always_ff @(posedge clk) begin
        if (out_accept) begin
            fifo_data_o <= data_i[7:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stall and read data
    //////////////////////////////////////////////////////////////////////

    // Timer load stalls its first cycle only, print store while FIFO full
    assign stall_o = (is_load && hit_timer && !stall_r) || (out_store && fifo_full_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_r <= 1'b0;
        end else begin
            stall_r <= stall_o;
        end
    end

    // Two read stages, timer captured in the first access cycle only
    always_ff @(posedge clk) begin
        data_r <= (is_load && hit_timer && !stall_r) ? timer_count_i : '0;
        data_o <= data_r;
    end

endmodule

`default_nettype wire

// ==== rtl/periph_irq_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_irq_timer #(
    parameter periph_pkg::word_t TIMER_LIMIT = 32'h0EE6_B280
) (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          btn_level_i,
    input  wire logic          interrupt_ack_i,
    output periph_pkg::word_t  timer_count_o,
    output periph_pkg::word_t  irq_o
);

    logic btn_level_r;   // Previous debounced level
    logic btn_rise;
    logic btn_req;       // Sticky until acknowledged
    logic ack_ext;       // Ack goes to the button interrupt
    logic ack_timer;     // Ack goes to the timer interrupt

    // External interrupt wins the acknowledge
    assign ack_ext   = interrupt_ack_i && irq_o[periph_pkg::IRQ_EXT_BIT];
    assign ack_timer = interrupt_ack_i && !irq_o[periph_pkg::IRQ_EXT_BIT];

    //////////////////////////////////////////////////////////////////////
    // Timer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || ack_timer) begin
            timer_count_o <= '0;
        end else begin
            timer_count_o <= timer_count_o + 32'd1;   // Free running
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Button edge and request
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            btn_level_r <= 1'b0;
        end else begin
            btn_level_r <= btn_level_i;
        end
    end

    assign btn_rise = btn_level_i && !btn_level_r;

    always_ff @(posedge clk) begin
        if (reset || ack_ext) begin
            btn_req <= 1'b0;
        end else if (btn_rise) begin
            btn_req <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Interrupt vector
    //////////////////////////////////////////////////////////////////////

    // Unused vector bits stay at reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_o <= '0;
        end else begin
            if (ack_ext) begin
                irq_o[periph_pkg::IRQ_EXT_BIT] <= 1'b0;
            end else if (btn_req) begin
                irq_o[periph_pkg::IRQ_EXT_BIT] <= 1'b1;
            end
            if (ack_timer) begin
                irq_o[periph_pkg::IRQ_TIMER_BIT] <= 1'b0;
            end else if (timer_count_o >= TIMER_LIMIT) begin
                irq_o[periph_pkg::IRQ_TIMER_BIT] <= 1'b1;   // Limit reached
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/debouncer.sv ====
`timescale 1ns/1ns
`default_nettype none

module debouncer #(
    parameter int DEBNC_CLOCKS = 2**16
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  signal_i,
    output logic       signal_o
);

    localparam int CNT_W = $clog2(DEBNC_CLOCKS + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBNC_CLOCKS - 1);

    logic [1:0]       sync_q;   // Two flop synchronizer
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[0], signal_i};
        end
    end

    // Count while the input differs from the accepted level
    always_ff @(posedge clk) begin
        if (reset) begin
            stable_cnt <= '0;
            signal_o   <= 1'b0;
        end else if (sync_q[1] == signal_o) begin
            stable_cnt <= '0;               // Glitch back, start over
        end else if (stable_cnt == CNT_LAST) begin
            stable_cnt <= '0;
            signal_o   <= sync_q[1];        // Stable long enough
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_tx_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               push_i,
    input  wire periph_pkg::byte_t  data_i,
    input  wire logic               pop_i,
    output periph_pkg::byte_t       data_o,
    output logic                    full_o,
    output logic                    empty_o
);

    localparam int DEPTH = 2**FIFO_DEPTH_LOG2;

    periph_pkg::byte_t          mem [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr, rd_ptr;   // Wrap naturally
    logic [FIFO_DEPTH_LOG2:0]   count;            // Occupancy 0..DEPTH

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither
            endcase
        end
    end

    // Head byte always visible
    assign data_o = mem[rd_ptr];

    assign full_o  = (count == (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
    assign empty_o = (count == '0);

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               send_i,
    input  wire periph_pkg::byte_t  data_i,
    output logic                    ready_o,
    output logic                    tx_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    periph_pkg::uart_state_t state;
    periph_pkg::byte_t       data_r;     // Latched frame payload
    logic [CNT_W-1:0]        baud_cnt;
    logic [2:0]              bit_idx;
    logic [2:0]              next_idx;
    logic                    bit_done;   // Last clock of a bit

    assign bit_done = (baud_cnt == BIT_LAST);
    assign next_idx = bit_idx + 3'd1;
    assign ready_o  = (state == periph_pkg::IDLE);

    // Payload capture
    always_ff @(posedge clk) begin
        if (ready_o && send_i) begin
            data_r <= data_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bit state machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= periph_pkg::IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx_o     <= 1'b1;                  // Line idles high
        end else begin
            baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
            case (state)
                periph_pkg::IDLE: begin
                    baud_cnt <= '0;
                    if (send_i) begin
                        state <= periph_pkg::START;
                        tx_o  <= 1'b0;         // Start bit
                    end
                end
                periph_pkg::START: begin
                    if (bit_done) begin
                        state   <= periph_pkg::DATA;
                        bit_idx <= '0;
                        tx_o    <= data_r[0];  // LSB first
                    end
                end
                periph_pkg::DATA: begin
                    if (bit_done && bit_idx == 3'd7) begin
                        state <= periph_pkg::STOP;
                        tx_o  <= 1'b1;         // Stop bit
                    end else if (bit_done) begin
                        bit_idx <= next_idx;
                        tx_o    <= data_r[next_idx];
                    end
                end
                periph_pkg::STOP: begin
                    if (bit_done) begin
                        state <= periph_pkg::IDLE;
                    end
                end
                default: state <= periph_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/peripherals.sv ====
`timescale 1ns/1ns
`default_nettype none

module peripherals #(
    parameter periph_pkg::word_t TIMER_LIMIT     = 32'h0EE6_B280,  // About 2.5 s at 100 MHz
    parameter int                DEBNC_CLOCKS    = 2**16,
    parameter int                FIFO_DEPTH_LOG2 = 4,
    parameter int                CLKS_PER_BIT    = 868             // 115200 baud
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  enable_i,
    input  wire periph_pkg::wstrb_t    write_enable_i,
    input  wire periph_pkg::word_t     data_address_i,
    input  wire periph_pkg::word_t     data_i,
    input  wire logic                  btn_i,
    input  wire logic                  interrupt_ack_i,
    output periph_pkg::word_t          data_o,
    output logic                       stall_o,
    output periph_pkg::word_t          irq_o,
    output periph_pkg::byte_t          gpio_out_o,
    output periph_pkg::gpio_tag_t      gpio_tag_o,
    output logic                       uart_tx_o
);

    periph_pkg::word_t timer_count;
    logic              btn_level;
    logic              fifo_push, fifo_pop, fifo_full, fifo_empty;
    periph_pkg::byte_t fifo_data, fifo_head;
    logic              uart_send, uart_ready;
    periph_pkg::byte_t uart_data;

    //////////////////////////////////////////////////////////////////////
    // Bus side
    //////////////////////////////////////////////////////////////////////

    periph_bus_decode decode_inst (
        .clk            (clk),
        .reset          (reset),
        .enable_i       (enable_i),
        .write_enable_i (write_enable_i),
        .data_address_i (data_address_i),
        .data_i         (data_i),
        .fifo_full_i    (fifo_full),
        .timer_count_i  (timer_count),
        .gpio_out_o     (gpio_out_o),
        .gpio_tag_o     (gpio_tag_o),
        .fifo_push_o    (fifo_push),
        .fifo_data_o    (fifo_data),
        .stall_o        (stall_o),
        .data_o         (data_o)
    );

    // Button path into the interrupt unit
    debouncer #(.DEBNC_CLOCKS(DEBNC_CLOCKS)) debouncer_inst (
        .clk      (clk),
        .reset    (reset),
        .signal_i (btn_i),
        .signal_o (btn_level)
    );

    periph_irq_timer #(.TIMER_LIMIT(TIMER_LIMIT)) irq_timer_inst (
        .clk             (clk),
        .reset           (reset),
        .btn_level_i     (btn_level),
        .interrupt_ack_i (interrupt_ack_i),
        .timer_count_o   (timer_count),
        .irq_o           (irq_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Print queue and serial line
    //////////////////////////////////////////////////////////////////////

    uart_tx_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) fifo_inst (
        .clk     (clk),
        .reset   (reset),
        .push_i  (fifo_push),
        .data_i  (fifo_data),
        .pop_i   (fifo_pop),
        .data_o  (fifo_head),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

    // No pop while a send is in flight
    assign fifo_pop = uart_ready && !fifo_empty && !uart_send;

    // Send one cycle after the pop, byte taken from the head at pop time
    always_ff @(posedge clk) begin
        if (reset) begin
            uart_send <= 1'b0;
        end else begin
            uart_send <= fifo_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            uart_data <= fifo_head;
        end
    end

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_inst (
        .clk     (clk),
        .reset   (reset),
        .send_i  (uart_send),
        .data_i  (uart_data),
        .ready_o (uart_ready),
        .tx_o    (uart_tx_o)
    );

endmodule

`default_nettype wire

// ==== verification/peripherals_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module peripherals_tb;

    localparam periph_pkg::word_t TIMER_LIMIT = 32'd400;
    localparam int DEBNC_CLOCKS    = 4;
    localparam int FIFO_DEPTH_LOG2 = 2;     // Four byte queue
    localparam int CLKS_PER_BIT    = 8;
    localparam int CLK_PERIOD      = 8;
    localparam int STALL_LIMIT     = 40 * CLKS_PER_BIT;    // Well over one frame
    localparam int DRAIN_LIMIT     = 200 * CLKS_PER_BIT;

    logic                  clk;
    logic                  reset;
    logic                  enable_i;
    periph_pkg::wstrb_t    write_enable_i;
    periph_pkg::word_t     data_address_i;
    periph_pkg::word_t     data_i;
    logic                  btn_i;
    logic                  interrupt_ack_i;
    periph_pkg::word_t     data_o;
    logic                  stall_o;
    periph_pkg::word_t     irq_o;
    periph_pkg::byte_t     gpio_out_o;
    periph_pkg::gpio_tag_t gpio_tag_o;
    logic                  uart_tx_o;

    periph_pkg::byte_t exp_q[$];        // Bytes still due on the serial line
    int   seed = 12202;
    int   check_count = 0;
    int   error_count = 0;
    int   test_count = 0;
    int   failed_tests = 0;
    int   test_err_mark = 0;             // Errors before current test
    logic stall_seen;

    peripherals #(
        .TIMER_LIMIT     (TIMER_LIMIT),
        .DEBNC_CLOCKS    (DEBNC_CLOCKS),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2),
        .CLKS_PER_BIT    (CLKS_PER_BIT)
    ) peripherals_inst (
        .clk             (clk),
        .reset           (reset),
        .enable_i        (enable_i),
        .write_enable_i  (write_enable_i),
        .data_address_i  (data_address_i),
        .data_i          (data_i),
        .btn_i           (btn_i),
        .interrupt_ack_i (interrupt_ack_i),
        .data_o          (data_o),
        .stall_o         (stall_o),
        .irq_o           (irq_o),
        .gpio_out_o      (gpio_out_o),
        .gpio_tag_o      (gpio_tag_o),
        .uart_tx_o       (uart_tx_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Hard limit on the whole run
    initial begin
        #(CLK_PERIOD * 50000);
        $display("run did not finish within its time limit");
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and compares
    //////////////////////////////////////////////////////////////////////

    // Tag left by one bus cycle
    function automatic periph_pkg::gpio_tag_t expected_tag(input logic store,
                                                           input periph_pkg::word_t addr);
        if (!store) begin
            return 8'h00;                // Idle cycle clears the tag
        end
        if (addr == periph_pkg::ADDR_GPIO || addr == periph_pkg::ADDR_PRINT) begin
            return periph_pkg::TAG_OUTPUT;
        end
        if (addr == periph_pkg::ADDR_END) begin
            return periph_pkg::TAG_END;
        end
        return 8'h00;
    endfunction

    function automatic periph_pkg::word_t expected_irq(input logic timer_pending,
                                                       input logic ext_pending);
        periph_pkg::word_t v;
        v = '0;
        v[periph_pkg::IRQ_TIMER_BIT] = timer_pending;
        v[periph_pkg::IRQ_EXT_BIT]   = ext_pending;
        return v;
    endfunction

    task automatic compare_word(input string name, input periph_pkg::word_t actual,
                                input periph_pkg::word_t expected);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_byte(input string name, input periph_pkg::byte_t actual,
                                input periph_pkg::byte_t expected);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_tag(input string name, input periph_pkg::gpio_tag_t actual,
                               input periph_pkg::gpio_tag_t expected);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == test_err_mark) begin
            $display("test %s ok", name);
        end else begin
            failed_tests++;
            $display("test %s failed with %0d errors", name, error_count - test_err_mark);
        end
        test_err_mark = error_count;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus and interrupt tasks, entered and left on a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic bus_store(input periph_pkg::word_t addr, input periph_pkg::word_t data);
        int waited;
        waited = 0;
        enable_i       <= 1'b1;
        write_enable_i <= 4'b0001;       // Byte store
        data_address_i <= addr;
        data_i         <= data;
        @(negedge clk);
        while (stall_o && waited < STALL_LIMIT) begin
            stall_seen = 1'b1;
            waited++;
            @(negedge clk);
        end
        if (stall_o) begin
            $display("store to %h still stalled after %0d cycles", addr, STALL_LIMIT);
            error_count++;
        end else if (addr == periph_pkg::ADDR_GPIO || addr == periph_pkg::ADDR_PRINT) begin
            exp_q.push_back(data[7:0]);  // Every output store is queued
        end
        @(posedge clk);                  // Store taken here
        enable_i       <= 1'b0;
        write_enable_i <= '0;
    endtask

    task automatic bus_load(input periph_pkg::word_t addr, output periph_pkg::word_t value,
                            output time start);
        int waited;
        int edges;                       // Edges since the first access cycle
        waited = 0;
        edges  = 0;
        start  = $time;
        enable_i       <= 1'b1;
        write_enable_i <= '0;
        data_address_i <= addr;
        @(negedge clk);
        while (stall_o && waited < STALL_LIMIT) begin
            @(posedge clk);
            edges++;
            waited++;
            @(negedge clk);
        end
        if (stall_o) begin
            $display("load from %h still stalled after %0d cycles", addr, STALL_LIMIT);
            error_count++;
        end
        @(posedge clk);
        edges++;
        enable_i <= 1'b0;
        while (edges < 2) begin
            @(posedge clk);
            edges++;
        end
        @(negedge clk);
        value = data_o;                  // Valid two edges after access start
        @(posedge clk);
    endtask

    task automatic pulse_ack();
        interrupt_ack_i <= 1'b1;
        @(posedge clk);
        interrupt_ack_i <= 1'b0;
    endtask

    // Entered and left on a falling edge
    task automatic wait_irq_bit(input int unsigned bit_pos, input int limit, output int cycles);
        cycles = 0;
        while (!irq_o[bit_pos] && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!irq_o[bit_pos]) begin
            $display("irq_o bit %0d did not rise within %0d cycles", bit_pos, limit);
            error_count++;
        end
    endtask

    task automatic wait_uart_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("uart_tx_o still owes %0d bytes after %0d cycles", exp_q.size(), waited);
            error_count++;
            exp_q.delete();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Serial line monitor, compares against the expected queue
    //////////////////////////////////////////////////////////////////////

    initial begin : uart_monitor
        periph_pkg::byte_t rx;
        logic              frame_ok;
        int                i;
        forever begin
            @(negedge clk);
            if (reset === 1'b0 && uart_tx_o === 1'b0) begin
                frame_ok = 1'b1;
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);   // Middle of start bit
                if (uart_tx_o !== 1'b0) begin
                    frame_ok = 1'b0;
                end
                for (i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    rx[i] = uart_tx_o;                           // LSB first
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (uart_tx_o !== 1'b1) begin
                    frame_ok = 1'b0;                             // Stop bit missing
                end
                if (!frame_ok) begin
                    $display("bad start or stop bit on uart_tx_o");
                    error_count++;
                end else if (exp_q.size() == 0) begin
                    $display("uart_tx_o sent byte %h that no store asked for", rx);
                    error_count++;
                end else begin
                    compare_byte("uart_tx_o", rx, exp_q.pop_front());
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        periph_pkg::word_t v1, v2, v3;
        time               t1, t2;
        int                gap;
        int                cycles;
        reset           <= 1'b1;
        enable_i        <= 1'b0;
        write_enable_i  <= '0;
        data_address_i  <= '0;
        data_i          <= '0;
        btn_i           <= 1'b0;
        interrupt_ack_i <= 1'b0;
        stall_seen      = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // GPIO value and tag, then idle, then end marker
        v1 = $random(seed);
        bus_store(periph_pkg::ADDR_GPIO, v1);
        @(negedge clk);
        compare_byte("gpio_out_o", gpio_out_o, v1[7:0]);
        compare_tag("gpio_tag_o", gpio_tag_o, expected_tag(1'b1, periph_pkg::ADDR_GPIO));
        @(posedge clk);
        @(negedge clk);
        compare_byte("gpio_out_o", gpio_out_o, 8'h00);
        compare_tag("gpio_tag_o", gpio_tag_o, expected_tag(1'b0, periph_pkg::ADDR_GPIO));
        @(posedge clk);
        v2 = $random(seed);
        bus_store(periph_pkg::ADDR_GPIO, v2);
        bus_store(periph_pkg::ADDR_END, 32'd0);
        @(negedge clk);
        compare_byte("gpio_out_o", gpio_out_o, v2[7:0]);    // Kept by end marker
        compare_tag("gpio_tag_o", gpio_tag_o, expected_tag(1'b1, periph_pkg::ADDR_END));
        @(posedge clk);
        finish_test("gpio store");

        repeat (6) begin
            v1 = $random(seed);
            bus_store(periph_pkg::ADDR_PRINT, v1);
            repeat (3) @(posedge clk);
        end
        wait_uart_drain();
        finish_test("print order");

        // Store loop, one idle cycle per pass, overruns the queue
        stall_seen = 1'b0;
        repeat (10) begin
            v1 = $random(seed);
            bus_store(periph_pkg::ADDR_PRINT, v1);
            @(posedge clk);
        end
        if (!stall_seen) begin
            $display("stall_o never rose during the print burst");
            error_count++;
        end
        wait_uart_drain();
        finish_test("print back-pressure");

        bus_load(periph_pkg::ADDR_TIMER, v1, t1);
        gap = 5 + int'($unsigned($random(seed)) % 16);
        repeat (gap) @(posedge clk);
        bus_load(periph_pkg::ADDR_TIMER, v2, t2);
        @(negedge clk);
        compare_word("data_o", data_o, 32'd0);               // Back to zero after the read
        @(posedge clk);
        compare_word("data_o delta", v2 - v1, periph_pkg::word_t'((t2 - t1) / CLK_PERIOD));
        bus_load(periph_pkg::ADDR_GPIO, v3, t1);
        compare_word("data_o", v3, 32'd0);                   // Not readable
        finish_test("timer read");

        pulse_ack();                                         // Timer restarts
        @(negedge clk);
        compare_word("irq_o", irq_o, expected_irq(1'b0, 1'b0));
        wait_irq_bit(periph_pkg::IRQ_TIMER_BIT, TIMER_LIMIT + 50, cycles);
        compare_word("timer irq delay", cycles, TIMER_LIMIT + 1);
        compare_word("irq_o", irq_o, expected_irq(1'b1, 1'b0));
        @(posedge clk);
        pulse_ack();
        @(negedge clk);
        compare_word("irq_o", irq_o, expected_irq(1'b0, 1'b0));
        @(posedge clk);
        finish_test("timer irq");

        // Glitches shorter than the debounce time
        repeat (3) begin
            btn_i <= 1'b1;
            repeat (DEBNC_CLOCKS - 2) @(posedge clk);
            btn_i <= 1'b0;
            repeat (DEBNC_CLOCKS) @(posedge clk);
        end
        repeat (DEBNC_CLOCKS + 4) @(posedge clk);
        @(negedge clk);
        compare_word("irq_o", irq_o, expected_irq(1'b0, 1'b0));
        @(posedge clk);
        btn_i <= 1'b1;                                       // Real press, held
        @(negedge clk);
        wait_irq_bit(periph_pkg::IRQ_EXT_BIT, DEBNC_CLOCKS + 20, cycles);
        compare_word("irq_o", irq_o, expected_irq(1'b0, 1'b1));
        wait_irq_bit(periph_pkg::IRQ_TIMER_BIT, TIMER_LIMIT + 50, cycles);
        compare_word("irq_o", irq_o, expected_irq(1'b1, 1'b1));
        @(posedge clk);
        pulse_ack();                                         // Button goes first
        @(negedge clk);
        compare_word("irq_o", irq_o, expected_irq(1'b1, 1'b0));
        @(posedge clk);
        pulse_ack();
        @(negedge clk);
        compare_word("irq_o", irq_o, expected_irq(1'b0, 1'b0));
        @(posedge clk);
        btn_i <= 1'b0;
        finish_test("button irq priority");

        // Catch late or duplicated frames
        wait_uart_drain();
        repeat (12 * CLKS_PER_BIT) @(posedge clk);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== peripherals.f ====
rtl/periph_pkg.sv
rtl/periph_bus_decode.sv
rtl/periph_irq_timer.sv
rtl/debouncer.sv
rtl/uart_tx_fifo.sv
rtl/uart_tx.sv
rtl/peripherals.sv
verification/peripherals_tb.sv

// ==== Makefile ====
# Verilator simulation of the peripheral block

TOP := peripherals_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench into sim.log, check the result"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f peripherals.f -o sim
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	grep -q "^STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
